/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cdp_lut_ctrl
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
STIMULUS  ?= sim/cdp_lut_stimulus.txt
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hdl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass line on stdout
run: $(BIN) $(STIMULUS)
	$(BIN) | tee /dev/stderr | grep -qF -e '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

/* hdl/cdp_lut_ctrl.sv */
module cdp_lut_ctrl import cdp_lut_pkg::*; (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  logic       sum2itp_pvld,
  output logic       sum2itp_prdy,
  input  sum_data_t  sum2itp_pd,
  input  logic       lut_le_function,
  input  lut_ofs_t   lut_le_index_offset,
  input  lut_shift_t lut_le_index_select,
  input  sum_wide_t  lut_le_start_low,
  input  lut_shift_t lut_lo_index_select,
  input  sum_wide_t  lut_lo_start_low,
  input  logic       sqsum_bypass,
  output logic       dp2lut_pvld,
  input  logic       dp2lut_prdy,
  output lut_index_t dp2lut_x_pd,
  output lut_info_t  dp2lut_x_info,
  output lut_index_t dp2lut_y_pd,
  output lut_info_t  dp2lut_y_info
);

  // fork outputs
  sum_wide_t  fork_data;
  logic       exp_mode;
  lut_shift_t y_shift_sel;
  logic       x_in_valid, x_in_ready;
  logic       y_in_valid, y_in_ready;
  // x chain
  logic       x_ofs_valid, x_ofs_ready, x_ofs_uflow;
  sum_wide_t  x_ofs_value;
  logic       x_log_valid, x_log_ready, x_log_uflow;
  sum_wide_t  x_log_value;
  lut_frac_t  x_log_frac;
  logic       x_out_valid, x_out_ready;
  // y chain
  logic       y_ofs_valid, y_ofs_ready, y_ofs_uflow;
  sum_wide_t  y_ofs_value;
  logic       y_out_valid, y_out_ready;

  cdp_lut_in_fork u_in_fork (
    .nvdla_core_clk, .nvdla_core_rstn,
    .sum2itp_pvld, .sum2itp_prdy, .sum2itp_pd,
    .lut_le_function, .lut_lo_index_select, .sqsum_bypass,
    .x_ready(x_in_ready), .y_ready(y_in_ready),
    .x_valid(x_in_valid), .y_valid(y_in_valid),
    .data(fork_data), .exp_mode, .y_shift_sel
  );

  ////////////////////////////////////////////////////////////
  // x table
  ////////////////////////////////////////////////////////////
  cdp_lut_offset_sub u_x_offset (
    .nvdla_core_clk, .nvdla_core_rstn,
    .in_valid(x_in_valid), .in_ready(x_in_ready),
    .in_data(fork_data), .start(lut_le_start_low),
    .out_valid(x_ofs_valid), .out_ready(x_ofs_ready),
    .out_value(x_ofs_value), .out_uflow(x_ofs_uflow)
  );

  cdp_lut_x_log2 u_x_log2 (
    .nvdla_core_clk, .nvdla_core_rstn, .exp_mode,
    .in_valid(x_ofs_valid), .in_ready(x_ofs_ready),
    .in_value(x_ofs_value), .in_uflow(x_ofs_uflow),
    .out_valid(x_log_valid), .out_ready(x_log_ready),
    .out_value(x_log_value), .out_frac(x_log_frac), .out_uflow(x_log_uflow)
  );

  cdp_lut_x_index u_x_index (
    .nvdla_core_clk, .nvdla_core_rstn, .exp_mode,
    .lut_le_index_offset, .lut_le_index_select,
    .in_valid(x_log_valid), .in_ready(x_log_ready),
    .in_value(x_log_value), .in_frac(x_log_frac), .in_uflow(x_log_uflow),
    .out_valid(x_out_valid), .out_ready(x_out_ready),
    .out_index(dp2lut_x_pd), .out_info(dp2lut_x_info)
  );

  ////////////////////////////////////////////////////////////
  // y table
  ////////////////////////////////////////////////////////////
  cdp_lut_offset_sub u_y_offset (
    .nvdla_core_clk, .nvdla_core_rstn,
    .in_valid(y_in_valid), .in_ready(y_in_ready),
    .in_data(fork_data), .start(lut_lo_start_low),
    .out_valid(y_ofs_valid), .out_ready(y_ofs_ready),
    .out_value(y_ofs_value), .out_uflow(y_ofs_uflow)
  );

  cdp_lut_y_shift u_y_shift (
    .nvdla_core_clk, .nvdla_core_rstn, .y_shift_sel,
    .in_valid(y_ofs_valid), .in_ready(y_ofs_ready),
    .in_value(y_ofs_value), .in_uflow(y_ofs_uflow),
    .out_valid(y_out_valid), .out_ready(y_out_ready),
    .out_index(dp2lut_y_pd), .out_info(dp2lut_y_info)
  );

  // x and y leave together
  cdp_lut_out_join u_out_join (
    .x_valid(x_out_valid), .x_ready(x_out_ready),
    .y_valid(y_out_valid), .y_ready(y_out_ready),
    .dp2lut_pvld, .dp2lut_prdy
  );

endmodule

/* hdl/cdp_lut_defines.svh */
`ifndef CDP_LUT_DEFINES_SVH
`define CDP_LUT_DEFINES_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

// sum-of-squares input, 21 bits after the lrn window
`define CDP_SUM_W 21

// table index and fraction
`define CDP_LUT_INDEX_W 10
`define CDP_LUT_FRAC_W 16

////////////////////////////////////////////////////////////
// saturation limits per table
////////////////////////////////////////////////////////////

// x table is 65 entries, last entry is the clamp
`define CDP_X_INDEX_MAX 64
// y table is 257 entries
`define CDP_Y_INDEX_MAX 256

`endif

/* hdl/cdp_lut_in_fork.sv */
`include "cdp_lut_defines.svh"

module cdp_lut_in_fork import cdp_lut_pkg::*; (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  logic       sum2itp_pvld,
  output logic       sum2itp_prdy,
  input  sum_data_t  sum2itp_pd,
  input  logic       lut_le_function,
  input  lut_shift_t lut_lo_index_select,
  input  logic       sqsum_bypass,
  input  logic       x_ready,
  input  logic       y_ready,
  output logic       x_valid,
  output logic       y_valid,
  output sum_wide_t  data,
  output logic       exp_mode,
  output lut_shift_t y_shift_sel
);

  logic bypass_en;

  // mode config, one cycle behind the register inputs
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      exp_mode    <= 1'b0;
      y_shift_sel <= '0;
      bypass_en   <= 1'b0;
    end else begin
      // function 0 selects the exponent table
      exp_mode    <= (lut_le_function == 1'b0);
      y_shift_sel <= lut_lo_index_select;
      bypass_en   <= sqsum_bypass;
    end
  end

  // bypassed sum is already signed data
  assign data = bypass_en ? {sum2itp_pd[`CDP_SUM_W-1], sum2itp_pd} : {1'b0, sum2itp_pd};

  // both tables take the item in the same cycle
  assign x_valid      = sum2itp_pvld & y_ready;
  assign y_valid      = sum2itp_pvld & x_ready;
  assign sum2itp_prdy = x_ready & y_ready;

endmodule

/* hdl/cdp_lut_offset_sub.sv */
module cdp_lut_offset_sub import cdp_lut_pkg::*; (
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  input  logic      in_valid,
  output logic      in_ready,
  input  sum_wide_t in_data,
  input  sum_wide_t start,
  output logic      out_valid,
  input  logic      out_ready,
  output sum_wide_t out_value,
  output logic      out_uflow
);

  logic load;
  logic below_start;

  // single entry stage
  assign in_ready = ~out_valid | out_ready;
  assign load     = in_valid & in_ready;

  // at or below the window start
  assign below_start = ($signed(in_data) <= $signed(start));

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // payload
  always_ff @(posedge nvdla_core_clk) begin
    if (load) begin
      if (below_start) begin
        out_value <= '0;
        out_uflow <= 1'b1;
      end else begin
        // always positive here
        out_value <= in_data - start;
        out_uflow <= 1'b0;
      end
    end
  end

endmodule

/* hdl/cdp_lut_out_join.sv */
module cdp_lut_out_join (
  input  logic x_valid,
  output logic x_ready,
  input  logic y_valid,
  output logic y_ready,
  output logic dp2lut_pvld,
  input  logic dp2lut_prdy
);

  ////////////////////////////////////////////////////////////
  // x/y output interlock
  ////////////////////////////////////////////////////////////

  // valid only once both tables hold a result
  assign dp2lut_pvld = x_valid & y_valid;

  // pop one side only with the other
  assign x_ready = dp2lut_prdy & y_valid;
  assign y_ready = dp2lut_prdy & x_valid;

  // y usually arrives first and waits here

endmodule

/* hdl/cdp_lut_pkg.sv */
`include "cdp_lut_defines.svh"

package cdp_lut_pkg;

  // raw input sum
  typedef logic [`CDP_SUM_W-1:0] sum_data_t;
  // widened by one bit, signed where compared
  typedef logic [`CDP_SUM_W:0] sum_wide_t;
  typedef logic [`CDP_LUT_INDEX_W-1:0] lut_index_t;
  typedef logic [`CDP_LUT_FRAC_W-1:0] lut_frac_t;
  // oflow, uflow, frac
  typedef logic [`CDP_LUT_FRAC_W+1:0] lut_info_t;
  // index select field, bits 5:0 signed
  typedef logic [7:0] lut_shift_t;
  typedef logic signed [7:0] lut_ofs_t;

  ////////////////////////////////////////////////////////////
  // shift and saturate, shared by x and y
  ////////////////////////////////////////////////////////////
  function automatic lut_index_t lut_index_shift(
    input  sum_wide_t   value,
    input  lut_shift_t  sel,
    input  int unsigned limit,
    output logic        oflow,
    output lut_frac_t   frac
  );
    // integer part above bit 22, shifted-out bits below
    logic [75:0] shifted;
    logic [53:0] int_part;
    logic [5:0]  amt;
    lut_index_t  index;
    shifted = {32'd0, value, 22'd0};
    if (sel[5]) begin
      // negative select, magnitude 1..32
      amt = {1'b0, ~sel[4:0]} + 6'd1;
      shifted = shifted >> amt;
      frac = shifted[21:6];
    end else begin
      shifted = shifted << sel[4:0];
      frac = '0;
    end
    int_part = shifted[75:22];
    // clamp at the last table entry
    if (int_part >= limit) begin
      index = lut_index_t'(limit);
      oflow = 1'b1;
    end else begin
      index = int_part[`CDP_LUT_INDEX_W-1:0];
      oflow = 1'b0;
    end
    return index;
  endfunction

endpackage

/* hdl/cdp_lut_x_index.sv */
`include "cdp_lut_defines.svh"

module cdp_lut_x_index import cdp_lut_pkg::*; (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  logic       exp_mode,
  input  lut_ofs_t   lut_le_index_offset,
  input  lut_shift_t lut_le_index_select,
  input  logic       in_valid,
  output logic       in_ready,
  input  sum_wide_t  in_value,
  input  lut_frac_t  in_frac,
  input  logic       in_uflow,
  output logic       out_valid,
  input  logic       out_ready,
  output lut_index_t out_index,
  output lut_info_t  out_info
);

  // stage 1 regs
  logic       s1_valid, s1_ready;
  sum_wide_t  s1_value;
  lut_frac_t  s1_frac;
  logic       s1_uflow;
  logic       load1, load2;
  logic       idx_below;
  // stage 2 combinational
  lut_shift_t shift_sel;
  lut_index_t shift_index;
  lut_frac_t  lin_frac;
  logic       shift_oflow;

  assign in_ready = ~s1_valid | s1_ready;
  assign s1_ready = ~out_valid | out_ready;
  assign load1    = in_valid & in_ready;
  assign load2    = s1_valid & s1_ready;

  ////////////////////////////////////////////////////////////
  // stage 1, exponent index offset
  ////////////////////////////////////////////////////////////
  // only a non-negative offset can push the index below zero
  assign idx_below = ~lut_le_index_offset[7] &
                     (in_value < sum_wide_t'(lut_le_index_offset[6:0]));

  always_ff @(posedge nvdla_core_clk) begin
    if (load1) begin
      s1_frac <= in_frac;
      if (exp_mode && !in_uflow && idx_below) begin
        s1_value <= '0;
        s1_uflow <= 1'b1;
      end else if (exp_mode && !in_uflow) begin
        s1_value <= in_value - {{(`CDP_SUM_W-7){lut_le_index_offset[7]}}, lut_le_index_offset};
        s1_uflow <= 1'b0;
      end else begin
        // linear value, or zero from an input uflow
        s1_value <= in_value;
        s1_uflow <= in_uflow;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 2, shift and saturate
  ////////////////////////////////////////////////////////////
  // exponent table is indexed by the exponent itself
  assign shift_sel   = exp_mode ? '0 : lut_le_index_select;
  always_comb begin
    shift_index = lut_index_shift(s1_value, shift_sel, `CDP_X_INDEX_MAX, shift_oflow, lin_frac);
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (load1) begin
        s1_valid <= 1'b1;
      end else if (s1_ready) begin
        s1_valid <= 1'b0;
      end
      if (load2) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (load2) begin
      out_index <= s1_uflow ? '0 : shift_index;
      out_info  <= {~s1_uflow & shift_oflow, s1_uflow, exp_mode ? s1_frac : lin_frac};
    end
  end

endmodule

/* hdl/cdp_lut_x_log2.sv */
`include "cdp_lut_defines.svh"

module cdp_lut_x_log2 import cdp_lut_pkg::*; (
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  input  logic      exp_mode,
  input  logic      in_valid,
  output logic      in_ready,
  input  sum_wide_t in_value,
  input  logic      in_uflow,
  output logic      out_valid,
  input  logic      out_ready,
  output sum_wide_t out_value,
  output lut_frac_t out_frac,
  output logic      out_uflow
);

  logic      load;
  logic [4:0] lead;
  sum_wide_t aligned;

  assign in_ready = ~out_valid | out_ready;
  assign load     = in_valid & in_ready;

  // leading one, bit 0 alone counts as zero
  always_comb begin
    lead = '0;
    for (int i = 1; i <= `CDP_SUM_W; i++) begin
      if (in_value[i]) begin
        lead = 5'(i);
      end
    end
  end

  // bits below the leading one, left aligned to bit 20
  assign aligned = in_value << (5'd21 - lead);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (load) begin
      out_uflow <= in_uflow;
      if (exp_mode && !in_uflow && lead != 5'd0) begin
        out_value <= sum_wide_t'(lead);
        // top 16 of the 21-bit mantissa
        out_frac  <= aligned[`CDP_SUM_W-1:`CDP_SUM_W-`CDP_LUT_FRAC_W];
      end else if (exp_mode) begin
        out_value <= '0;
        out_frac  <= '0;
      end else begin
        // linear table, log2 bypassed
        out_value <= in_value;
        out_frac  <= '0;
      end
    end
  end

endmodule

/* hdl/cdp_lut_y_shift.sv */
`include "cdp_lut_defines.svh"

module cdp_lut_y_shift import cdp_lut_pkg::*; (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  lut_shift_t y_shift_sel,
  input  logic       in_valid,
  output logic       in_ready,
  input  sum_wide_t  in_value,
  input  logic       in_uflow,
  output logic       out_valid,
  input  logic       out_ready,
  output lut_index_t out_index,
  output lut_info_t  out_info
);

  logic       load;
  lut_index_t shift_index;
  lut_frac_t  lin_frac;
  logic       shift_oflow;

  assign in_ready = ~out_valid | out_ready;
  assign load     = in_valid & in_ready;

  // y is linear only
  always_comb begin
    shift_index = lut_index_shift(in_value, y_shift_sel, `CDP_Y_INDEX_MAX, shift_oflow, lin_frac);
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // uflow clears index, oflow and frac
  always_ff @(posedge nvdla_core_clk) begin
    if (load) begin
      out_index <= in_uflow ? '0 : shift_index;
      out_info  <= in_uflow ? {2'b01, `CDP_LUT_FRAC_W'(0)} : {shift_oflow, 1'b0, lin_frac};
    end
  end

endmodule

/* sim/cdp_lut_stimulus.txt */
# c le_function le_index_offset le_index_select le_start_low lo_index_select lo_start_low sqsum_bypass
# d sum2itp_pd x_index x_info y_index y_info   (all hex, info = oflow uflow frac)
# linear, x right 4, y left 2, both starts 0x10
c 1 00 3c 000010 02 000010 0
d 000114 010 04000 100 20000
d 000013 000 03000 00c 00000
d 000410 040 20000 100 20000
d 00004f 003 0f000 0fc 00000
d 000050 004 00000 100 20000
d 000010 000 10000 000 10000
# linear, x left 1, y right 8 with start 0x100
c 1 00 01 000000 38 000100 0
d 000020 040 20000 000 10000
d 00011f 040 20000 000 01f00
d 012345 040 20000 100 24500
d 00a0ff 040 20000 09f 0ff00
# exponent x, index offset 3
c 0 03 00 000000 00 000000 0
d 000400 007 00000 100 20000
d 000600 007 08000 100 20000
d 000005 000 14000 005 00000
d 000001 000 10000 001 00000
d 1fffff 011 0ffff 100 20000
d 000000 000 10000 000 10000
# exponent x, index offset -2
c 0 fe 00 000000 00 000000 0
d 000003 003 08000 003 00000
d 000001 002 00000 001 00000
d 0c0000 015 08000 100 20000
# sum-of-squares bypass set, then cleared
c 1 00 00 000000 00 000000 1
d 1ffff0 000 10000 000 10000
d 000030 030 00000 030 00000
c 1 00 00 000000 00 000000 0
d 1ffff0 040 20000 100 20000

/* sim/tb_cdp_lut_ctrl.sv */
module tb_cdp_lut_ctrl import cdp_lut_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  logic       nvdla_core_clk;
  logic       nvdla_core_rstn;
  logic       sum2itp_pvld;
  logic       sum2itp_prdy;
  sum_data_t  sum2itp_pd;
  logic       lut_le_function;
  lut_ofs_t   lut_le_index_offset;
  lut_shift_t lut_le_index_select;
  sum_wide_t  lut_le_start_low;
  lut_shift_t lut_lo_index_select;
  sum_wide_t  lut_lo_start_low;
  logic       sqsum_bypass;
  logic       dp2lut_pvld;
  logic       dp2lut_prdy;
  lut_index_t dp2lut_x_pd;
  lut_info_t  dp2lut_x_info;
  lut_index_t dp2lut_y_pd;
  lut_info_t  dp2lut_y_info;

  // expected results, oldest at the front
  lut_index_t  exp_x_pd[$];
  lut_info_t   exp_x_info[$];
  lut_index_t  exp_y_pd[$];
  lut_info_t   exp_y_info[$];
  // config and data lines in file order
  string       lines[$];
  int          n_data;
  int          n_config;
  logic [31:0] lcg_state;

  cdp_lut_ctrl u_cdp_lut_ctrl (.*);

  // 100 ns clock
  initial begin
    nvdla_core_clk = 1'b0;
    forever #50 nvdla_core_clk = ~nvdla_core_clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_index(input string name, input lut_index_t got, input lut_index_t want);
    if (got !== want) begin
      abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  task automatic check_info(input string name, input lut_info_t got, input lut_info_t want);
    if (got !== want) begin
      abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  // ansi c rand constants
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // keep only config and data lines, count them for the watchdog
  task automatic read_stimulus();
    int    fd;
    string line;
    fd = $fopen("sim/cdp_lut_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the stimulus file sim/cdp_lut_stimulus.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.getc(0) == "c") begin
          n_config++;
          lines.push_back(line);
        end else if (line.getc(0) == "d") begin
          n_data++;
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  // new mode only with the pipeline empty, then 2 cycles to settle
  task automatic apply_config(input string line);
    logic       fn;
    logic       byp;
    lut_ofs_t   ofs;
    lut_shift_t le_sel;
    lut_shift_t lo_sel;
    sum_wide_t  le_start;
    sum_wide_t  lo_start;
    int         got;
    got = $sscanf(line, "c %h %h %h %h %h %h %h",
                  fn, ofs, le_sel, le_start, lo_sel, lo_start, byp);
    if (got != 7) begin
      abort_run({"malformed config line in stimulus file: ", line});
    end else begin
      while (exp_x_pd.size() != 0) begin
        @(negedge nvdla_core_clk);
      end
      lut_le_function     = fn;
      lut_le_index_offset = ofs;
      lut_le_index_select = le_sel;
      lut_le_start_low    = le_start;
      lut_lo_index_select = lo_sel;
      lut_lo_start_low    = lo_start;
      sqsum_bypass        = byp;
      repeat (2) @(negedge nvdla_core_clk);
    end
  endtask

  // queue the expected pair, hold valid until the fork takes it
  task automatic send_item(input string line);
    sum_data_t  value;
    lut_index_t x_pd;
    lut_info_t  x_info;
    lut_index_t y_pd;
    lut_info_t  y_info;
    logic       taken;
    int         got;
    got = $sscanf(line, "d %h %h %h %h %h", value, x_pd, x_info, y_pd, y_info);
    if (got != 5) begin
      abort_run({"malformed data line in stimulus file: ", line});
    end else begin
      exp_x_pd.push_back(x_pd);
      exp_x_info.push_back(x_info);
      exp_y_pd.push_back(y_pd);
      exp_y_info.push_back(y_info);
      taken        = 1'b0;
      sum2itp_pvld = 1'b1;
      sum2itp_pd   = value;
      while (!taken) begin
        // prdy settled well before the rising edge
        #10;
        taken = sum2itp_prdy;
        @(negedge nvdla_core_clk);
      end
      sum2itp_pvld = 1'b0;
    end
  endtask

  task automatic check_result();
    if (exp_x_pd.size() == 0) begin
      abort_run("the DUT produced a result that no data line asked for");
    end else begin
      check_index("dp2lut_x_pd", dp2lut_x_pd, exp_x_pd.pop_front());
      check_info("dp2lut_x_info", dp2lut_x_info, exp_x_info.pop_front());
      check_index("dp2lut_y_pd", dp2lut_y_pd, exp_y_pd.pop_front());
      check_info("dp2lut_y_info", dp2lut_y_info, exp_y_info.pop_front());
    end
  endtask

  ////////////////////////////////////////////////////////////
  // output side, random back-pressure and result compare
  ////////////////////////////////////////////////////////////
  initial begin
    lcg_state   = 32'd13;
    dp2lut_prdy = 1'b0;
    forever begin
      @(negedge nvdla_core_clk);
      lcg_state = lcg_next(lcg_state);
      // ready about three cycles in four
      dp2lut_prdy = (lcg_state[17:16] != 2'b00);
      #10;
      // transfer happens on the coming rising edge
      if (dp2lut_pvld && dp2lut_prdy) begin
        check_result();
      end
    end
  end

  // watchdog, 40 cycles per item plus config and reset slack
  initial begin
    @(posedge nvdla_core_rstn);
    repeat (40 * n_data + 8 * n_config + 20) @(posedge nvdla_core_clk);
    abort_run("timeout: the DUT did not return all results within the cycle limit");
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    nvdla_core_rstn     = 1'b0;
    sum2itp_pvld        = 1'b0;
    sum2itp_pd          = '0;
    lut_le_function     = 1'b1;
    lut_le_index_offset = '0;
    lut_le_index_select = '0;
    lut_le_start_low    = '0;
    lut_lo_index_select = '0;
    lut_lo_start_low    = '0;
    sqsum_bypass        = 1'b0;
    n_data              = 0;
    n_config            = 0;
    read_stimulus();
    repeat (4) @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
    // idle right out of reset
    #10;
    check_flag("dp2lut_pvld", dp2lut_pvld, 1'b0);
    check_flag("sum2itp_prdy", sum2itp_prdy, 1'b1);
    @(negedge nvdla_core_clk);
    foreach (lines[i]) begin
      if (lines[i].getc(0) == "c") begin
        apply_config(lines[i]);
      end else begin
        send_item(lines[i]);
      end
    end
    // drain, then a few idle cycles to catch extra results
    while (exp_x_pd.size() != 0) begin
      @(negedge nvdla_core_clk);
    end
    repeat (10) @(negedge nvdla_core_clk);
    $display("** PASS **");
    $finish;
  end

endmodule

/* src.f */
+incdir+hdl
hdl/cdp_lut_pkg.sv
hdl/cdp_lut_in_fork.sv
hdl/cdp_lut_offset_sub.sv
hdl/cdp_lut_x_log2.sv
hdl/cdp_lut_x_index.sv
hdl/cdp_lut_y_shift.sv
hdl/cdp_lut_out_join.sv
hdl/cdp_lut_ctrl.sv
sim/tb_cdp_lut_ctrl.sv
